/* verilog.f */
seq_pkg.sv
conv_pkg.sv
seq_table.sv
conv_ctrl.sv
shift_counter.sv
dabble_datapath.sv
ascii_formatter.sv
seq_generator.sv
tb_clk_gen.sv
tb_seq_generator.sv

/* Makefile */
VERILATOR  = verilator
BUILD_FLAGS = --binary --timing
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_seq_generator
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
PASS_TEXT  = >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q -x -F -- '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

/* tb_seq_generator.sv */
// testbench for seq_generator: random stimulus, reference model, checks and timeouts
`timescale 1ns/1ps

module tb_seq_generator import seq_pkg::*; import conv_pkg::*; ();

	localparam logic [31:0] SEED = 32'h67c1_05a2;
	localparam int CREATE_LATENCY = 36;	// create drive to valid_o seen
	localparam int VALID_TIMEOUT = 100;
	localparam int QUIET_WINDOW = 40;		// longer than one conversion

	logic clk;
	logic rst;
	logic update_i;
	logic [HOST_ADDR_WIDTH-1:0] update_addr_i;
	logic [SEQ_WIDTH-1:0] update_value_i;
	logic create_i;
	logic ignore_i;
	logic [HOST_ADDR_WIDTH-1:0] create_addr_i;
	logic receive_i;
	logic [HOST_ADDR_WIDTH-1:0] receive_addr_i;
	logic [SEQ_WIDTH-1:0] expected_seq_num_o;
	logic [ASCII_WIDTH-1:0] outgoing_seq_num_o;
	logic [DIGIT_COUNT_WIDTH-1:0] width_o;
	logic valid_o;

	logic [SEQ_WIDTH-1:0] model_seq [NUM_HOSTS];	// reference counters

	tb_clk_gen i_clk_gen (.clk_o(clk));

	seq_generator i_dut (
		.clk(clk), .rst(rst),
		.update_i(update_i), .update_addr_i(update_addr_i), .update_value_i(update_value_i),
		.create_i(create_i), .ignore_i(ignore_i), .create_addr_i(create_addr_i),
		.receive_i(receive_i), .receive_addr_i(receive_addr_i),
		.expected_seq_num_o(expected_seq_num_o), .outgoing_seq_num_o(outgoing_seq_num_o),
		.width_o(width_o), .valid_o(valid_o)
	);

	task automatic stop_run();
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [ASCII_WIDTH-1:0] expected,
			input logic [ASCII_WIDTH-1:0] actual);
		if (actual !== expected) begin
			$display("error: %s expected 0x%h actual 0x%h", name, expected, actual);
			stop_run();
		end
	endtask

	// decimal text, leading digit in byte 0
	function automatic logic [ASCII_WIDTH-1:0] decimal_text(input logic [SEQ_WIDTH-1:0] value);
		logic [ASCII_WIDTH-1:0] text;
		logic [7:0] rev [BCD_DIGITS];
		logic [SEQ_WIDTH-1:0] rest;
		int n;
		text = '0;
		rest = value;
		n = 0;
		do begin
			rev[n] = 8'h30 + 8'(rest % 10);	// least significant first
			rest = rest / 10;
			n++;
		end while (rest != 0);
		for (int k = 0; k < n; k++) begin
			text[k*8 +: 8] = rev[n-1-k];
		end
		return text;
	endfunction

	function automatic logic [DIGIT_COUNT_WIDTH-1:0] decimal_width(input logic [SEQ_WIDTH-1:0] value);
		logic [SEQ_WIDTH-1:0] rest;
		int n;
		rest = value;
		n = 1;
		while (rest >= 10) begin
			rest = rest / 10;
			n++;
		end
		return DIGIT_COUNT_WIDTH'(n);
	endfunction

	function automatic logic [HOST_ADDR_WIDTH-1:0] random_host();
		return HOST_ADDR_WIDTH'($urandom_range(0, NUM_HOSTS - 1));
	endfunction

	task automatic clear_strobes();
		update_i = 1'b0;
		create_i = 1'b0;
		ignore_i = 1'b0;
		receive_i = 1'b0;
	endtask

	task automatic do_receive(input logic [HOST_ADDR_WIDTH-1:0] addr);
		@(negedge clk);
		receive_i = 1'b1;
		receive_addr_i = addr;
		@(negedge clk);
		clear_strobes();
		check_value("expected_seq_num_o", ASCII_WIDTH'(model_seq[addr]),
			ASCII_WIDTH'(expected_seq_num_o));
	endtask

	task automatic do_update(input logic [HOST_ADDR_WIDTH-1:0] addr,
			input logic [SEQ_WIDTH-1:0] value);
		@(negedge clk);
		update_i = 1'b1;
		update_addr_i = addr;
		update_value_i = value;
		model_seq[addr] = value;
		@(negedge clk);
		clear_strobes();
	endtask

	// one-cycle create strobe, returns at the following falling edge
	task automatic drive_create(input logic [HOST_ADDR_WIDTH-1:0] addr, input logic ign);
		@(negedge clk);
		create_i = 1'b1;
		ignore_i = ign;
		create_addr_i = addr;
		if (!ign) begin
			model_seq[addr] = model_seq[addr] + 1'b1;	// wraps like the table
		end
		@(negedge clk);
		clear_strobes();
	endtask

	task automatic wait_valid(input int elapsed, output int latency);
		latency = elapsed;	// edges already spent since the create was driven
		while (valid_o !== 1'b1) begin
			if (latency >= VALID_TIMEOUT) begin
				$display("timed out waiting for valid_o after a create");
				stop_run();
			end
			@(negedge clk);
			latency++;
		end
	endtask

	task automatic expect_no_valid(input int cycles, input string cause);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			if (valid_o === 1'b1) begin
				$display("valid_o appeared after %s", cause);
				stop_run();
			end
		end
	endtask

	task automatic check_conversion(input logic [SEQ_WIDTH-1:0] value, input int elapsed);
		int latency;
		wait_valid(elapsed, latency);
		check_value("create latency", ASCII_WIDTH'(CREATE_LATENCY), ASCII_WIDTH'(latency));
		check_value("outgoing_seq_num_o", decimal_text(value), outgoing_seq_num_o);
		check_value("width_o", ASCII_WIDTH'(decimal_width(value)), ASCII_WIDTH'(width_o));
		@(negedge clk);
		check_value("valid_o", ASCII_WIDTH'(1'b0), ASCII_WIDTH'(valid_o));	// single pulse
	endtask

	task automatic create_and_check(input logic [HOST_ADDR_WIDTH-1:0] addr);
		drive_create(addr, 1'b0);
		check_conversion(model_seq[addr], 1);	// drive_create spent one edge
	endtask

	initial begin
		logic [HOST_ADDR_WIDTH-1:0] h;
		logic [HOST_ADDR_WIDTH-1:0] g;
		logic [SEQ_WIDTH-1:0] v;
		logic [SEQ_WIDTH-1:0] first;
		void'($urandom(SEED));
		rst = 1'b1;
		clear_strobes();
		update_addr_i = '0;
		update_value_i = '0;
		create_addr_i = '0;
		receive_addr_i = '0;
		for (int i = 0; i < NUM_HOSTS; i++) begin
			model_seq[i] = SEQ_RESET_VALUE;
		end
		repeat (5) @(negedge clk);
		rst = 1'b0;
		check_value("valid_o", '0, ASCII_WIDTH'(valid_o));
		check_value("width_o", '0, ASCII_WIDTH'(width_o));
		check_value("outgoing_seq_num_o", '0, outgoing_seq_num_o);

		for (int i = 0; i < NUM_HOSTS; i++) begin
			do_receive(HOST_ADDR_WIDTH'(i));	// every counter starts at one
		end

		// random creates over small, medium and full-width values
		for (int n = 0; n < 24; n++) begin
			h = random_host();
			case ($urandom_range(0, 3))
				0: do_update(h, $urandom_range(0, 98));
				1: do_update(h, $urandom_range(100, 999999));
				2: do_update(h, $urandom_range(32'd999999999, 32'hfffffffe));
				default: ;
			endcase
			create_and_check(h);
		end

		// ignored create
		h = random_host();
		drive_create(h, 1'b1);
		expect_no_valid(QUIET_WINDOW, "an ignored create");
		do_receive(h);

		// resync writes read back
		for (int n = 0; n < 10; n++) begin
			h = random_host();
			do_update(h, $urandom());
			do_receive(h);
		end

		// update and create in one cycle, the create is dropped
		h = random_host();
		g = random_host();
		v = $urandom();
		@(negedge clk);
		update_i = 1'b1;
		update_addr_i = h;
		update_value_i = v;
		create_i = 1'b1;
		create_addr_i = g;
		model_seq[h] = v;
		@(negedge clk);
		clear_strobes();
		expect_no_valid(QUIET_WINDOW, "a create that met an update");
		do_receive(h);
		do_receive(g);

		// wraparound to zero
		h = random_host();
		do_update(h, 32'hffffffff);
		create_and_check(h);
		do_receive(h);	// table holds zero

		// second create during a busy conversion
		h = random_host();
		drive_create(h, 1'b0);
		first = model_seq[h];
		repeat (5) @(negedge clk);
		drive_create(h, 1'b0);	// controller busy, no text
		check_conversion(first, 8);	// one, five and two edges since the first create
		expect_no_valid(QUIET_WINDOW, "a create during a running conversion");
		do_receive(h);

		$display(">>> PASS");
		$finish;
	end

endmodule

/* tb_clk_gen.sv */
// testbench clock source with a 40 ns period
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_o
);

	localparam time HALF_PERIOD = 20ns;

	initial begin
		clk_o = 1'b0;
	end

	always begin
		#HALF_PERIOD clk_o = ~clk_o;
	end

endmodule

/* seq_generator.sv */
// sequence generator top: counter table, conversion control and datapaths
`timescale 1ns/1ps

module seq_generator import seq_pkg::*; import conv_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic update_i,
	input  logic [HOST_ADDR_WIDTH-1:0] update_addr_i,
	input  logic [SEQ_WIDTH-1:0] update_value_i,
	input  logic create_i,
	input  logic ignore_i,
	input  logic [HOST_ADDR_WIDTH-1:0] create_addr_i,
	input  logic receive_i,
	input  logic [HOST_ADDR_WIDTH-1:0] receive_addr_i,
	output logic [SEQ_WIDTH-1:0] expected_seq_num_o,
	output logic [ASCII_WIDTH-1:0] outgoing_seq_num_o,
	output logic [DIGIT_COUNT_WIDTH-1:0] width_o,
	output logic valid_o
);

	logic [SEQ_WIDTH-1:0] next_value;
	logic create_done;
	logic load;
	logic shift_en;
	logic fmt_en;
	logic last;
	bcd_word_u digits;

	seq_table i_table (
		.clk(clk), .rst(rst),
		.update_i(update_i), .update_addr_i(update_addr_i), .update_value_i(update_value_i),
		.create_i(create_i), .ignore_i(ignore_i), .create_addr_i(create_addr_i),
		.receive_i(receive_i), .receive_addr_i(receive_addr_i),
		.next_value_o(next_value), .create_done_o(create_done),
		.expected_seq_num_o(expected_seq_num_o)
	);

	conv_ctrl i_ctrl (
		.clk(clk), .rst(rst),
		.create_done_i(create_done), .last_i(last),
		.load_o(load), .shift_en_o(shift_en), .fmt_en_o(fmt_en), .valid_o(valid_o)
	);

	shift_counter i_counter (
		.clk(clk), .rst(rst),
		.load_i(load), .shift_en_i(shift_en), .last_o(last)
	);

	dabble_datapath i_dabble (
		.clk(clk), .rst(rst),
		.load_i(load), .shift_en_i(shift_en), .next_value_i(next_value),
		.digits_o(digits)
	);

	ascii_formatter i_format (
		.clk(clk), .rst(rst),
		.fmt_en_i(fmt_en), .digits_i(digits),
		.outgoing_seq_num_o(outgoing_seq_num_o), .width_o(width_o)
	);

endmodule

/* ascii_formatter.sv */
// bcd digits to ascii text with leading digit in byte 0, plus digit count
`timescale 1ns/1ps

module ascii_formatter import conv_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic fmt_en_i,
	input  bcd_word_u digits_i,
	output logic [ASCII_WIDTH-1:0] outgoing_seq_num_o,
	output logic [DIGIT_COUNT_WIDTH-1:0] width_o
);

	logic [DIGIT_COUNT_WIDTH-1:0] count;
	logic [ASCII_WIDTH-1:0] text;

	// highest nonzero digit sets the count, zero still has one digit
	always_comb begin
		count = DIGIT_COUNT_WIDTH'(1);
		for (int i = 1; i < BCD_DIGITS; i++) begin
			if (digits_i.digit[i] != '0) begin
				count = DIGIT_COUNT_WIDTH'(i + 1);
			end
		end
	end

	// byte k carries digit count-1-k, bytes past the count stay zero
	always_comb begin
		text = '0;
		for (int k = 0; k < BCD_DIGITS; k++) begin
			if (k < int'(count)) begin
				text[k*8 +: 8] = ASCII_ZERO + 8'(digits_i.digit[int'(count) - 1 - k]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			outgoing_seq_num_o <= '0;
			width_o <= '0;
		end else if (fmt_en_i) begin
			outgoing_seq_num_o <= text;
			width_o <= count;
		end
	end

endmodule

/* dabble_datapath.sv */
// serial binary to bcd engine with shift register and add-3 digit correction
`timescale 1ns/1ps

module dabble_datapath import seq_pkg::*; import conv_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic load_i,
	input  logic shift_en_i,
	input  logic [SEQ_WIDTH-1:0] next_value_i,
	output bcd_word_u digits_o
);

	logic [SEQ_WIDTH-1:0] bin_q;
	bcd_word_u bcd_q;
	bcd_word_u bcd_fix;

	// any digit of 5 or more would pass 9 after doubling
	always_comb begin
		bcd_fix = bcd_q;
		for (int d = 0; d < BCD_DIGITS; d++) begin
			if (bcd_q.digit[d] >= 4'd5) begin
				bcd_fix.digit[d] = bcd_q.digit[d] + 4'd3;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			bin_q <= '0;
			bcd_q <= '0;
		end else if (load_i) begin
			bin_q <= next_value_i;
			bcd_q <= '0;
		end else if (shift_en_i) begin
			bin_q <= {bin_q[SEQ_WIDTH-2:0], 1'b0};
			bcd_q.flat <= {bcd_fix.flat[BCD_WIDTH-2:0], bin_q[SEQ_WIDTH-1]};	// msb first
		end
	end

	assign digits_o = bcd_q;

endmodule

/* shift_counter.sv */
// shift step counter that flags the last bit of a conversion
`timescale 1ns/1ps

module shift_counter import seq_pkg::*; import conv_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic load_i,
	input  logic shift_en_i,
	output logic last_o
);

	localparam logic [SHIFT_COUNT_WIDTH-1:0] LAST_STEP = SHIFT_COUNT_WIDTH'(SEQ_WIDTH - 1);

	logic [SHIFT_COUNT_WIDTH-1:0] count_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			count_q <= '0;
		end else if (load_i) begin
			count_q <= '0;
		end else if (shift_en_i) begin
			count_q <= count_q + 1'b1;
		end
	end

	assign last_o = shift_en_i && (count_q == LAST_STEP);	// 32nd step

endmodule

/* conv_ctrl.sv */
// conversion state machine for load, shift, format and valid pulse
`timescale 1ns/1ps

module conv_ctrl import conv_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic create_done_i,
	input  logic last_i,
	output logic load_o,
	output logic shift_en_o,
	output logic fmt_en_o,
	output logic valid_o
);

	logic [STATE_WIDTH-1:0] state_q;
	logic [STATE_WIDTH-1:0] state_d;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (create_done_i) begin
					state_d = ST_SHIFT;
				end
			end
			ST_SHIFT: begin
				if (last_i) begin
					state_d = ST_FORMAT;	// final bit goes in this cycle
				end
			end
			ST_FORMAT: state_d = ST_DONE;
			ST_DONE: state_d = ST_IDLE;
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= ST_IDLE;
			valid_o <= 1'b0;
		end else begin
			state_q <= state_d;
			valid_o <= (state_q == ST_DONE);	// text already registered
		end
	end

	// requests outside idle are dropped
	assign load_o = (state_q == ST_IDLE) && create_done_i;
	assign shift_en_o = (state_q == ST_SHIFT);
	assign fmt_en_o = (state_q == ST_FORMAT);

endmodule

/* seq_table.sv */
// per-host sequence counter memory with resync, increment and inbound lookup
`timescale 1ns/1ps

module seq_table import seq_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic update_i,					// resync from session manager
	input  logic [HOST_ADDR_WIDTH-1:0] update_addr_i,
	input  logic [SEQ_WIDTH-1:0] update_value_i,
	input  logic create_i,					// outgoing message
	input  logic ignore_i,
	input  logic [HOST_ADDR_WIDTH-1:0] create_addr_i,
	input  logic receive_i,					// inbound message
	input  logic [HOST_ADDR_WIDTH-1:0] receive_addr_i,
	output logic [SEQ_WIDTH-1:0] next_value_o,
	output logic create_done_o,
	output logic [SEQ_WIDTH-1:0] expected_seq_num_o
);

	logic [SEQ_WIDTH-1:0] mem_q [NUM_HOSTS];
	logic create_ok;
	logic [SEQ_WIDTH-1:0] inc_value;

	// resync wins over an increment in the same cycle
	assign create_ok = create_i && !ignore_i && !update_i;
	assign inc_value = mem_q[create_addr_i] + 1'b1;	// wraps at 2^32

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_HOSTS; i++) begin
				mem_q[i] <= SEQ_RESET_VALUE;
			end
		end else if (update_i) begin
			mem_q[update_addr_i] <= update_value_i;
		end else if (create_ok) begin
			mem_q[create_addr_i] <= inc_value;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			create_done_o <= 1'b0;
		end else begin
			create_done_o <= create_ok;	// one-cycle start strobe
		end
	end

	// value handed to the converter
	always_ff @(posedge clk) begin
		if (create_ok) begin
			next_value_o <= inc_value;
		end
	end

	// lookup sees the counter before any write in this cycle
	always_ff @(posedge clk) begin
		if (receive_i) begin
			expected_seq_num_o <= mem_q[receive_addr_i];
		end
	end

endmodule

/* conv_pkg.sv */
// conversion constants, controller state codes and the bcd word union type
package conv_pkg;

	localparam int BCD_DIGITS = 10;		// enough for 2^32 - 1
	localparam int DIGIT_BITS = 4;
	localparam int BCD_WIDTH = BCD_DIGITS * DIGIT_BITS;
	localparam int ASCII_WIDTH = BCD_DIGITS * 8;	// one byte per digit
	localparam int DIGIT_COUNT_WIDTH = 4;
	localparam int SHIFT_COUNT_WIDTH = 6;

	localparam logic [7:0] ASCII_ZERO = 8'h30;

	// controller states
	localparam int STATE_WIDTH = 2;
	localparam logic [STATE_WIDTH-1:0] ST_IDLE = 2'd0;
	localparam logic [STATE_WIDTH-1:0] ST_SHIFT = 2'd1;
	localparam logic [STATE_WIDTH-1:0] ST_FORMAT = 2'd2;
	localparam logic [STATE_WIDTH-1:0] ST_DONE = 2'd3;

	// flat view shifts the whole register, digit view is corrected and mapped per digit
	typedef union packed {
		logic [BCD_WIDTH-1:0] flat;
		logic [BCD_DIGITS-1:0][DIGIT_BITS-1:0] digit;	// digit 0 is least significant
	} bcd_word_u;

endpackage

/* seq_pkg.sv */
// host table constants: address width, table depth, counter width, reset value
package seq_pkg;

	// up to 16 peer hosts
	localparam int HOST_ADDR_WIDTH = 4;
	localparam int NUM_HOSTS = 1 << HOST_ADDR_WIDTH;

	// one binary sequence counter per host
	localparam int SEQ_WIDTH = 32;

	// sessions start numbering at one
	localparam logic [SEQ_WIDTH-1:0] SEQ_RESET_VALUE = 32'd1;

endpackage
